//--- hdl/phone_ui_pkg.sv
package phone_ui_pkg;

	////////////////////
	// widths
	////////////////////
	typedef logic [7:0] node_address_t;  // dialed party, from the switches
	typedef logic [10:0] text_addr_t;    // start in the text store
	typedef logic [10:0] text_len_t;     // string length in characters

	////////////////////
	// enums
	////////////////////
	typedef enum logic [2:0] {
		idle_st     = 3'd0, // no call
		incoming_st = 3'd1, // being called
		outgoing_st = 3'd2, // calling another node
		busy_st     = 3'd3, // call in progress
		init_st     = 3'd5  // waiting for network init
	} call_state_t;

	// item codes follow the old menu numbering
	typedef enum logic [5:0] {
		call_number        = 6'd0,
		display_number     = 6'd3,
		dialing            = 6'd7,
		toggle_voicemail   = 6'd9,
		incoming_banner    = 6'd32,
		accept_call_item   = 6'd33,
		reject_call_item   = 6'd34,
		calling_banner     = 6'd36,
		end_call_item      = 6'd37,
		call_banner        = 6'd38,
		end_call_busy_item = 6'd39,
		welcome            = 6'd50,
		init_banner        = 6'd51
	} menu_item_t;

	typedef enum logic [1:0] {nav_hold, nav_prev, nav_next, nav_jump} nav_op_t;

	// ui -> application
	typedef enum logic [2:0] {
		cmd_make_call   = 3'd1,
		cmd_stop_call   = 3'd2,
		cmd_accept_call = 3'd3,
		cmd_reject_call = 3'd4
	} ui_command_t;

	// application -> ui
	typedef enum logic [2:0] {
		ev_connected     = 3'd1,
		ev_failed        = 3'd4,
		ev_incoming_call = 3'd5,
		ev_call_ended    = 3'd6
	} app_event_t;

	localparam logic [5:0] item_none = 6'h3f; // no item has this code

	////////////////////
	// text store layout
	////////////////////
	localparam text_addr_t txt_init_addr    = 11'd0;   // press enter to start ...
	localparam text_len_t  txt_init_len     = 11'd45;
	localparam text_addr_t txt_welcome_addr = 11'd72;
	localparam text_len_t  txt_welcome_len  = 11'd7;
	localparam text_addr_t txt_call_addr    = 11'd80;  // call number
	localparam text_len_t  txt_call_len     = 11'd11;
	localparam text_addr_t txt_vm_on_addr   = 11'd157; // shown while flag is off
	localparam text_len_t  txt_vm_on_len    = 11'd17;
	localparam text_addr_t txt_vm_off_addr  = 11'd138; // shown while flag is on
	localparam text_len_t  txt_vm_off_len   = 11'd18;
	localparam text_addr_t txt_disp_addr    = 11'd468;
	localparam text_len_t  txt_disp_len     = 11'd21;
	localparam text_addr_t txt_inc_addr     = 11'd361;
	localparam text_len_t  txt_inc_len      = 11'd13;
	localparam text_addr_t txt_accept_addr  = 11'd375;
	localparam text_len_t  txt_accept_len   = 11'd20;
	localparam text_addr_t txt_reject_addr  = 11'd396;
	localparam text_len_t  txt_reject_len   = 11'd20;
	localparam text_addr_t txt_calling_addr = 11'd435;
	localparam text_len_t  txt_calling_len  = 11'd7;
	localparam text_addr_t txt_end_addr     = 11'd443; // both end call items
	localparam text_len_t  txt_end_len      = 11'd8;
	localparam text_addr_t txt_current_addr = 11'd490;
	localparam text_len_t  txt_current_len  = 11'd12;
	localparam text_addr_t txt_dial_addr    = 11'd0;   // number is on the switches
	localparam text_len_t  txt_dial_len     = 11'd0;

endpackage

//--- hdl/call_control.sv
`timescale 1ns/100ps
module call_control import phone_ui_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  logic          up,
	input  logic          down,
	input  logic          left,
	input  logic          right,
	input  logic          enter,
	input  node_address_t switches,
	input  logic          app_event_req,
	input  app_event_t    app_event,
	input  logic          cmd_busy,
	input  menu_item_t    menu_item,
	output logic          app_event_ack,
	output nav_op_t       nav_op,
	output menu_item_t    jump_item,
	output logic          cmd_send,
	output ui_command_t   cmd_code,
	output node_address_t cmd_address,
	output call_state_t   call_state,
	output logic          voicemail_on
);

	call_state_t state_nx;
	ui_command_t code_nx;
	logic        vm_nx;
	logic        send_nx;
	logic        ack_nx;
	logic        event_new;   // req seen, not yet answered
	logic        cmd_blocked; // port still owns the last command

	assign event_new   = app_event_req && !app_event_ack;
	assign cmd_blocked = cmd_busy || cmd_send; // send pulse not yet seen by port

	////////////////////
	// next state
	////////////////////
	always_comb begin
		nav_op    = nav_hold;
		jump_item = menu_item;
		state_nx  = call_state;
		vm_nx     = voicemail_on;
		send_nx   = 1'b0;
		code_nx   = cmd_make_call;
		ack_nx    = app_event_ack;
		if (app_event_ack && !app_event_req)
			ack_nx = 1'b0; // app released, close the handshake
		if (event_new) begin
			ack_nx = 1'b1; // events win over buttons
			case (app_event)
				ev_incoming_call: if (call_state == idle_st) begin
					state_nx  = incoming_st;
					nav_op    = nav_jump;
					jump_item = incoming_banner;
				end
				ev_connected: if (call_state == outgoing_st) begin
					state_nx  = busy_st;
					nav_op    = nav_jump;
					jump_item = call_banner;
				end
				ev_failed, ev_call_ended: begin
					// failed only counts while dialing out
					if (call_state == outgoing_st ||
						(call_state == busy_st && app_event == ev_call_ended)) begin
						state_nx  = idle_st;
						nav_op    = nav_jump;
						jump_item = welcome;
					end
				end
				default: ; // acked, nothing else
			endcase
		end else if (up) begin
			nav_op = nav_prev;
		end else if (down) begin
			nav_op = nav_next;
		end else if (right || enter) begin
			case (call_state)
				init_st: if (enter) begin // right does not start the node
					state_nx  = idle_st;
					nav_op    = nav_jump;
					jump_item = welcome;
				end
				idle_st: case (menu_item)
					welcome: begin
						nav_op    = nav_jump;
						jump_item = call_number;
					end
					call_number: begin
						nav_op    = nav_jump;
						jump_item = dialing;
					end
					dialing: if (!cmd_blocked) begin
						send_nx   = 1'b1;
						code_nx   = cmd_make_call;
						state_nx  = outgoing_st;
						nav_op    = nav_jump;
						jump_item = calling_banner;
					end
					toggle_voicemail: vm_nx = !voicemail_on;
					default: ;
				endcase
				incoming_st: if (!cmd_blocked) begin
					if (menu_item == reject_call_item) begin
						send_nx   = 1'b1;
						code_nx   = cmd_reject_call;
						state_nx  = idle_st;
						nav_op    = nav_jump;
						jump_item = welcome;
					end else begin // banner and accept both pick up
						send_nx   = 1'b1;
						code_nx   = cmd_accept_call;
						state_nx  = busy_st;
						nav_op    = nav_jump;
						jump_item = call_banner;
					end
				end
				outgoing_st, busy_st: begin
					// hang up, stay until app reports call_ended
					if (!cmd_blocked && (menu_item == end_call_item ||
						menu_item == end_call_busy_item)) begin
						send_nx = 1'b1;
						code_nx = cmd_stop_call;
					end
				end
				default: ;
			endcase
		end else if (left && call_state == idle_st) begin
			case (menu_item)
				call_number, toggle_voicemail, display_number: begin
					nav_op    = nav_jump; // back out of main menu
					jump_item = welcome;
				end
				dialing: begin
					nav_op    = nav_jump;
					jump_item = call_number;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			call_state    <= init_st;
			voicemail_on  <= 1'b0;
			app_event_ack <= 1'b0;
			cmd_send      <= 1'b0;
		end else begin
			call_state    <= state_nx;
			voicemail_on  <= vm_nx;
			app_event_ack <= ack_nx;
			cmd_send      <= send_nx; // one cycle pulse
		end
	end

	always_ff @(posedge clk) begin
		if (send_nx) begin
			cmd_code    <= code_nx;
			cmd_address <= switches; // only make_call reads it
		end
	end

	// ack only answers a pending request
	assert property (@(posedge clk) disable iff (reset)
		!app_event_ack && !app_event_req |=> !app_event_ack)
		else $error("app_event_ack rose without app_event_req");

endmodule

//--- hdl/menu_navigator.sv
`timescale 1ns/100ps
module menu_navigator import phone_ui_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  nav_op_t    nav_op,
	input  menu_item_t jump_item,
	output menu_item_t menu_item
);

	////////////////////
	// ring stepping
	////////////////////
	// fwd is down, back is up
	function automatic menu_item_t ring_step(input menu_item_t item, input logic fwd);
		menu_item_t nx;
		nx = item; // banners and dialing belong to no ring
		case (item)
			// main ring
			call_number:        nx = fwd ? toggle_voicemail : display_number;
			toggle_voicemail:   nx = fwd ? display_number : call_number;
			display_number:     nx = fwd ? call_number : toggle_voicemail;
			// incoming ring
			incoming_banner:    nx = fwd ? accept_call_item : reject_call_item;
			accept_call_item:   nx = fwd ? reject_call_item : incoming_banner;
			reject_call_item:   nx = fwd ? incoming_banner : accept_call_item;
			// two member rings, same either way
			calling_banner:     nx = end_call_item;
			end_call_item:      nx = calling_banner;
			call_banner:        nx = end_call_busy_item;
			end_call_busy_item: nx = call_banner;
			default:            nx = item;
		endcase
		return nx;
	endfunction

	////////////////////
	// item register
	////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			menu_item <= init_banner;
		end else begin
			case (nav_op)
				nav_prev: menu_item <= ring_step(menu_item, 1'b0);
				nav_next: menu_item <= ring_step(menu_item, 1'b1);
				nav_jump: menu_item <= jump_item; // set by call_control
				nav_hold: menu_item <= menu_item;
				default:  menu_item <= menu_item;
			endcase
		end
	end

	// jumps and steps only ever land on real items
	assert property (@(posedge clk) disable iff (reset)
		menu_item inside {init_banner, welcome, dialing, call_number, toggle_voicemail,
			display_number, incoming_banner, accept_call_item, reject_call_item,
			calling_banner, end_call_item, call_banner, end_call_busy_item})
		else $error("menu_item left the item set");

endmodule

//--- hdl/text_locator.sv
`timescale 1ns/100ps
module text_locator import phone_ui_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  menu_item_t menu_item,
	input  logic       voicemail_on,
	input  logic       text_ack,
	output logic       text_req,
	output text_addr_t text_addr,
	output text_len_t  text_length
);

	logic [5:0] last_item; // item of the last request
	logic       last_vm;   // flag of the last request
	logic       port_free;
	logic       changed;
	text_addr_t look_addr;
	text_len_t  look_len;

	assign port_free = !text_req && !text_ack; // old ack must fall first
	assign changed   = (last_item != menu_item) || (last_vm != voicemail_on);

	////////////////////
	// table lookup
	////////////////////
	always_comb begin
		look_addr = txt_init_addr;
		look_len  = txt_init_len;
		case (menu_item)
			init_banner:      begin look_addr = txt_init_addr;    look_len = txt_init_len;    end
			welcome:          begin look_addr = txt_welcome_addr; look_len = txt_welcome_len; end
			call_number:      begin look_addr = txt_call_addr;    look_len = txt_call_len;    end
			display_number:   begin look_addr = txt_disp_addr;    look_len = txt_disp_len;    end
			dialing:          begin look_addr = txt_dial_addr;    look_len = txt_dial_len;    end
			incoming_banner:  begin look_addr = txt_inc_addr;     look_len = txt_inc_len;     end
			accept_call_item: begin look_addr = txt_accept_addr;  look_len = txt_accept_len;  end
			reject_call_item: begin look_addr = txt_reject_addr;  look_len = txt_reject_len;  end
			calling_banner:   begin look_addr = txt_calling_addr; look_len = txt_calling_len; end
			call_banner:      begin look_addr = txt_current_addr; look_len = txt_current_len; end
			end_call_item, end_call_busy_item: begin
				look_addr = txt_end_addr;
				look_len  = txt_end_len;
			end
			toggle_voicemail: begin
				// text offers the opposite of the current flag
				look_addr = voicemail_on ? txt_vm_off_addr : txt_vm_on_addr;
				look_len  = voicemail_on ? txt_vm_off_len : txt_vm_on_len;
			end
			default: ;
		endcase
	end

	////////////////////
	// request to scroller
	////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			text_req  <= 1'b0;
			last_item <= item_none; // forces the init_banner request
			last_vm   <= 1'b0;
		end else if (text_req) begin
			if (text_ack)
				text_req <= 1'b0; // drop, then wait for ack low
		end else if (port_free && changed) begin
			text_req  <= 1'b1;
			last_item <= menu_item; // skipped items are never shown
			last_vm   <= voicemail_on;
		end
	end

	always_ff @(posedge clk) begin
		if (!text_req && port_free && changed) begin
			text_addr   <= look_addr;
			text_length <= look_len;
		end
	end

	// scroller may sample any cycle before it acks
	assert property (@(posedge clk) disable iff (reset)
		text_req && !text_ack |=> $stable(text_addr) && $stable(text_length))
		else $error("text request changed before text_ack");

endmodule

//--- hdl/command_port.sv
`timescale 1ns/100ps
module command_port import phone_ui_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  logic          cmd_send,
	input  ui_command_t   cmd_code_in,
	input  node_address_t cmd_address_in,
	input  logic          cmd_ack,
	output logic          cmd_req,
	output ui_command_t   cmd_code,
	output node_address_t cmd_address,
	output logic          cmd_busy
);

	typedef enum logic [1:0] {
		cp_idle,    // nothing pending
		cp_req,     // req high, waiting ack high
		cp_release  // req low, waiting ack low
	} port_state_t;

	port_state_t port_state;

	assign cmd_req  = (port_state == cp_req);
	assign cmd_busy = (port_state != cp_idle);

	////////////////////
	// four phase FSM
	////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			port_state <= cp_idle;
		end else begin
			case (port_state)
				cp_idle:    if (cmd_send) port_state <= cp_req;
				cp_req:     if (cmd_ack) port_state <= cp_release;
				cp_release: if (!cmd_ack) port_state <= cp_idle;
				default:    port_state <= cp_idle;
			endcase
		end
	end

	// payload held for the whole handshake
	always_ff @(posedge clk) begin
		if (cmd_send && port_state == cp_idle) begin
			cmd_code    <= cmd_code_in;
			cmd_address <= cmd_address_in;
		end
	end

	// call_control has to hold off while the port is busy
	assert property (@(posedge clk) disable iff (reset) cmd_send |-> !cmd_busy)
		else $error("cmd_send while command port busy");

endmodule

//--- hdl/phone_ui_top.sv
`timescale 1ns/100ps
module phone_ui_top import phone_ui_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	// buttons, one cycle pulses
	input  logic          up,
	input  logic          down,
	input  logic          left,
	input  logic          right,
	input  logic          enter,
	input  node_address_t switches,
	// application events
	input  logic          app_event_req,
	input  app_event_t    app_event,
	output logic          app_event_ack,
	// commands to application
	output logic          cmd_req,
	output ui_command_t   cmd_code,
	output node_address_t cmd_address,
	input  logic          cmd_ack,
	// text scroller
	output logic          text_req,
	output text_addr_t    text_addr,
	output text_len_t     text_length,
	input  logic          text_ack,
	// status
	output call_state_t   call_state,
	output menu_item_t    menu_item,
	output logic          voicemail_on
);

	nav_op_t       nav_op;
	menu_item_t    jump_item;
	logic          cmd_send;
	ui_command_t   send_code;    // call_control -> port
	node_address_t send_address;
	logic          cmd_busy;

	call_control i_call_control (
		.clk(clk), .reset(reset),
		.up(up), .down(down), .left(left), .right(right), .enter(enter),
		.switches(switches),
		.app_event_req(app_event_req), .app_event(app_event),
		.cmd_busy(cmd_busy), .menu_item(menu_item),
		.app_event_ack(app_event_ack),
		.nav_op(nav_op), .jump_item(jump_item),
		.cmd_send(cmd_send), .cmd_code(send_code), .cmd_address(send_address),
		.call_state(call_state), .voicemail_on(voicemail_on)
	);

	menu_navigator i_menu_navigator (
		.clk(clk), .reset(reset),
		.nav_op(nav_op), .jump_item(jump_item),
		.menu_item(menu_item)
	);

	text_locator i_text_locator (
		.clk(clk), .reset(reset),
		.menu_item(menu_item), .voicemail_on(voicemail_on),
		.text_ack(text_ack),
		.text_req(text_req), .text_addr(text_addr), .text_length(text_length)
	);

	command_port i_command_port (
		.clk(clk), .reset(reset),
		.cmd_send(cmd_send), .cmd_code_in(send_code), .cmd_address_in(send_address),
		.cmd_ack(cmd_ack),
		.cmd_req(cmd_req), .cmd_code(cmd_code), .cmd_address(cmd_address),
		.cmd_busy(cmd_busy)
	);

endmodule

//--- testbench/tb_phone_ui.sv
`timescale 1ns/100ps
module tb_phone_ui import phone_ui_pkg::*; ();

	logic          clk;
	logic          reset;
	logic          up;
	logic          down;
	logic          left;
	logic          right;
	logic          enter;
	node_address_t switches;
	logic          app_event_req;
	app_event_t    app_event;
	logic          app_event_ack;
	logic          cmd_req;
	ui_command_t   cmd_code;
	node_address_t cmd_address;
	logic          cmd_ack;
	logic          text_req;
	text_addr_t    text_addr;
	text_len_t     text_length;
	logic          text_ack;
	call_state_t   call_state;
	menu_item_t    menu_item;
	logic          voicemail_on;

	phone_ui_top i_dut (.*);

	typedef enum logic [1:0] {port_idle, port_req, port_release} port_model_t;

	// reference model
	call_state_t   m_state;
	menu_item_t    m_item;
	logic          m_vm;
	logic          m_ack;       // app_event_ack
	logic          m_send;      // command issued last edge
	port_model_t   m_port;
	logic          m_treq;
	logic          m_shown;     // any text asked for since reset
	menu_item_t    m_last_item;
	logic          m_last_vm;
	ui_command_t   cmd_q_code[$];
	node_address_t cmd_q_addr[$];
	ui_command_t   exp_code;
	node_address_t exp_addr;
	text_addr_t    exp_taddr;
	text_len_t     exp_tlen;
	integer        seed;
	int            cycle_count = 0;
	int            stim_cycles = 3000;
	int            cycle_limit = 3000 + 5 + 1000; // stimulus, reset, drain margin
	int            n_make = 0;
	int            n_stop = 0;
	int            n_accept = 0;
	int            n_reject = 0;
	int            n_toggle = 0;
	int            n_text = 0;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////
	// failure reporting
	////////////////////
	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit)
			stop_with_error("timeout: handshakes did not settle within the cycle limit");
	end

	task automatic check_state(input call_state_t got, input call_state_t want);
		if (got !== want)
			stop_with_error($sformatf("[FAIL] %0t call_state got %s (%0d) expected %s (%0d)",
				$time, got.name(), got, want.name(), want));
	endtask

	task automatic check_item(input menu_item_t got, input menu_item_t want);
		if (got !== want)
			stop_with_error($sformatf("[FAIL] %0t menu_item got %s (%0d) expected %s (%0d)",
				$time, got.name(), got, want.name(), want));
	endtask

	task automatic check_bit(input logic got, input logic want, input string name);
		if (got !== want)
			stop_with_error($sformatf("[FAIL] %0t %s got %b expected %b",
				$time, name, got, want));
	endtask

	task automatic check_command(input ui_command_t got_code, input ui_command_t want_code,
			input node_address_t got_addr, input node_address_t want_addr);
		if (got_code !== want_code)
			stop_with_error($sformatf("[FAIL] %0t cmd_code got %s (%0d) expected %s (%0d)",
				$time, got_code.name(), got_code, want_code.name(), want_code));
		if (want_code == cmd_make_call && got_addr !== want_addr) // only the call carries it
			stop_with_error($sformatf("[FAIL] %0t cmd_address got %h expected %h",
				$time, got_addr, want_addr));
	endtask

	task automatic check_text(input text_addr_t got_addr, input text_addr_t want_addr,
			input text_len_t got_len, input text_len_t want_len);
		if (got_addr !== want_addr)
			stop_with_error($sformatf("[FAIL] %0t text_addr got %0d expected %0d",
				$time, got_addr, want_addr));
		if (got_len !== want_len)
			stop_with_error($sformatf("[FAIL] %0t text_length got %0d expected %0d",
				$time, got_len, want_len));
	endtask

	////////////////////
	// menu rings and text table
	////////////////////
	function automatic menu_item_t next_in_ring(input menu_item_t item);
		case (item)
			call_number:        return toggle_voicemail;
			toggle_voicemail:   return display_number;
			display_number:     return call_number;
			incoming_banner:    return accept_call_item;
			accept_call_item:   return reject_call_item;
			reject_call_item:   return incoming_banner;
			calling_banner:     return end_call_item;
			end_call_item:      return calling_banner;
			call_banner:        return end_call_busy_item;
			end_call_busy_item: return call_banner;
			default:            return item; // banners, dialing
		endcase
	endfunction

	// walk forward until the step lands back on item
	function automatic menu_item_t prev_in_ring(input menu_item_t item);
		menu_item_t p;
		p = item;
		for (int i = 0; i < 3; i++)
			if (next_in_ring(p) != item)
				p = next_in_ring(p);
		return p;
	endfunction

	// {start, length}
	function automatic logic [21:0] text_entry(input menu_item_t item, input logic vm);
		case (item)
			init_banner:        return {11'd0, 11'd45};
			welcome:            return {11'd72, 11'd7};
			call_number:        return {11'd80, 11'd11};
			toggle_voicemail:   return vm ? {11'd138, 11'd18} : {11'd157, 11'd17}; // off : on
			display_number:     return {11'd468, 11'd21};
			incoming_banner:    return {11'd361, 11'd13};
			accept_call_item:   return {11'd375, 11'd20};
			reject_call_item:   return {11'd396, 11'd20};
			calling_banner:     return {11'd435, 11'd7};
			end_call_item,
			end_call_busy_item: return {11'd443, 11'd8};
			call_banner:        return {11'd490, 11'd12};
			default:            return {11'd0, 11'd0}; // dialing shows the switches
		endcase
	endfunction

	function automatic logic text_stale();
		return !m_shown || m_last_item != m_item || m_last_vm != m_vm;
	endfunction

	function automatic logic all_quiet();
		return !m_treq && !text_ack && !text_stale() && m_port == port_idle && !m_send
			&& !cmd_ack && !app_event_req && !m_ack;
	endfunction

	function automatic app_event_t event_code(input logic [1:0] sel);
		case (sel)
			2'd0:    return ev_connected;
			2'd1:    return ev_failed;
			2'd2:    return ev_incoming_call;
			default: return ev_call_ended;
		endcase
	endfunction

	task automatic queue_command(input ui_command_t code, input node_address_t addr);
		cmd_q_code.push_back(code);
		cmd_q_addr.push_back(addr);
		case (code)
			cmd_make_call:   n_make++;
			cmd_stop_call:   n_stop++;
			cmd_accept_call: n_accept++;
			default:         n_reject++;
		endcase
	endtask

	////////////////////
	// model, one clock edge
	////////////////////
	task automatic model_step();
		call_state_t ns;
		menu_item_t  ni;
		logic        nvm;
		logic        nack;
		logic        nsend;
		logic        blocked;
		ns      = m_state;
		ni      = m_item;
		nvm     = m_vm;
		nack    = m_ack;
		nsend   = 1'b0;
		blocked = m_send || (m_port != port_idle); // last command still in flight
		if (m_ack && !app_event_req)
			nack = 1'b0;
		if (app_event_req && !m_ack) begin // events beat buttons
			nack = 1'b1;
			if (app_event == ev_incoming_call && m_state == idle_st) begin
				ns = incoming_st;
				ni = incoming_banner;
			end else if (app_event == ev_connected && m_state == outgoing_st) begin
				ns = busy_st;
				ni = call_banner;
			end else if ((app_event == ev_failed && m_state == outgoing_st) ||
					(app_event == ev_call_ended &&
					(m_state == outgoing_st || m_state == busy_st))) begin
				ns = idle_st;
				ni = welcome;
			end
		end else if (up) begin
			ni = prev_in_ring(m_item);
		end else if (down) begin
			ni = next_in_ring(m_item);
		end else if (right || enter) begin
			if (m_state == init_st) begin
				if (enter) begin
					ns = idle_st;
					ni = welcome;
				end
			end else if (m_state == idle_st) begin
				case (m_item)
					welcome:     ni = call_number;
					call_number: ni = dialing;
					toggle_voicemail: begin
						nvm = !m_vm;
						n_toggle++;
					end
					dialing: if (!blocked) begin
						queue_command(cmd_make_call, switches);
						nsend = 1'b1;
						ns    = outgoing_st;
						ni    = calling_banner;
					end
					default: ;
				endcase
			end else if (m_state == incoming_st && !blocked) begin
				nsend = 1'b1;
				if (m_item == reject_call_item) begin
					queue_command(cmd_reject_call, switches);
					ns = idle_st;
					ni = welcome;
				end else begin
					queue_command(cmd_accept_call, switches);
					ns = busy_st;
					ni = call_banner;
				end
			end else if ((m_state == outgoing_st || m_state == busy_st) && !blocked &&
					(m_item == end_call_item || m_item == end_call_busy_item)) begin
				queue_command(cmd_stop_call, switches); // state waits for call_ended
				nsend = 1'b1;
			end
		end else if (left && m_state == idle_st) begin
			if (m_item == call_number || m_item == toggle_voicemail ||
					m_item == display_number)
				ni = welcome;
			else if (m_item == dialing)
				ni = call_number;
		end
		// text port sees the item as it was before this edge
		if (m_treq) begin
			if (text_ack) begin
				m_treq = 1'b0;
				n_text++;
			end
		end else if (!text_ack && text_stale()) begin
			m_treq      = 1'b1;
			m_shown     = 1'b1;
			m_last_item = m_item;
			m_last_vm   = m_vm;
			{exp_taddr, exp_tlen} = text_entry(m_item, m_vm);
		end
		case (m_port)
			port_idle: if (m_send) begin
				m_port   = port_req;
				exp_code = cmd_q_code.pop_front();
				exp_addr = cmd_q_addr.pop_front();
			end
			port_req:     if (cmd_ack) m_port = port_release;
			port_release: if (!cmd_ack) m_port = port_idle;
			default: ;
		endcase
		m_state = ns;
		m_item  = ni;
		m_vm    = nvm;
		m_ack   = nack;
		m_send  = nsend;
	endtask

	////////////////////
	// stimulus
	////////////////////
	task automatic send_event(input app_event_t ev);
		app_event_req <= 1'b1;
		app_event     <= ev;
	endtask

	task automatic answer_handshakes();
		logic [31:0] r;
		r = $random(seed);
		if (m_port == port_req && !cmd_ack && r[1:0] == 2'd0)
			cmd_ack <= 1'b1;
		else if (m_port != port_req && cmd_ack && r[3:2] == 2'd0)
			cmd_ack <= 1'b0;
		if (m_treq && !text_ack && r[5:4] == 2'd0)
			text_ack <= 1'b1;
		else if (!m_treq && text_ack && r[8:6] == 3'd0)
			text_ack <= 1'b0; // long hold lets items pile up
	endtask

	task automatic drive_inputs(input logic stimulate);
		logic [31:0] r;
		r = $random(seed);
		up    <= 1'b0;
		down  <= 1'b0;
		left  <= 1'b0;
		right <= 1'b0;
		enter <= 1'b0;
		if (stimulate) begin
			switches <= r[15:8];
			case (r[3:0])
				4'd0, 4'd1, 4'd2:    up <= 1'b1;
				4'd3, 4'd4, 4'd5:    down <= 1'b1;
				4'd6, 4'd7:          left <= 1'b1;
				4'd8, 4'd9, 4'd10:   right <= 1'b1;
				4'd11, 4'd12, 4'd13: enter <= 1'b1;
				default: ; // quiet cycle
			endcase
		end
		if (app_event_req) begin
			if (m_ack)
				app_event_req <= 1'b0;
		end else if (stimulate && !m_ack) begin
			case (m_state)
				// half connected, rest failed or call_ended
				outgoing_st: if (r[18:16] == 3'd0)
					send_event(r[20] ? ev_connected : event_code({r[19], 1'b1}));
				idle_st: if (r[20:16] == 5'd0) send_event(ev_incoming_call);
				busy_st: if (r[19:16] == 4'd0) send_event(ev_call_ended);
				default: ;
			endcase
			if (r[27:22] == 6'd0)
				send_event(event_code(r[29:28])); // stray, often ignored
		end
	endtask

	task automatic compare_outputs();
		check_state(call_state, m_state);
		check_item(menu_item, m_item);
		check_bit(voicemail_on, m_vm, "voicemail_on");
		check_bit(app_event_ack, m_ack, "app_event_ack");
		check_bit(cmd_req, m_port == port_req, "cmd_req");
		check_bit(text_req, m_treq, "text_req");
		if (m_port == port_req)
			check_command(cmd_code, exp_code, cmd_address, exp_addr);
		if (m_treq)
			check_text(text_addr, exp_taddr, text_length, exp_tlen);
	endtask

	// drive at the edge, check at the falling edge
	task automatic run_cycle(input logic stimulate);
		@(posedge clk);
		model_step();
		answer_handshakes();
		drive_inputs(stimulate);
		@(negedge clk);
		compare_outputs();
	endtask

	////////////////////
	// main sequence
	////////////////////
	initial begin
		seed          = 32'hcb031e1f;
		reset         <= 1'b1;
		up            <= 1'b0;
		down          <= 1'b0;
		left          <= 1'b0;
		right         <= 1'b0;
		enter         <= 1'b0;
		switches      <= 8'h00;
		app_event_req <= 1'b0;
		app_event     <= ev_connected;
		cmd_ack       <= 1'b0;
		text_ack      <= 1'b0;
		m_state       = init_st;
		m_item        = init_banner;
		m_vm          = 1'b0;
		m_ack         = 1'b0;
		m_send        = 1'b0;
		m_port        = port_idle;
		m_treq        = 1'b0;
		m_shown       = 1'b0;
		m_last_item   = init_banner;
		m_last_vm     = 1'b0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		compare_outputs(); // values straight out of reset
		for (int i = 0; i < stim_cycles; i++)
			run_cycle(1'b1);
		while (!all_quiet())
			run_cycle(1'b0); // let open handshakes finish
		$display("calls %0d, stops %0d, accepts %0d, rejects %0d, toggles %0d, texts %0d",
			n_make, n_stop, n_accept, n_reject, n_toggle, n_text);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- list.f
hdl/phone_ui_pkg.sv
hdl/call_control.sv
hdl/menu_navigator.sv
hdl/text_locator.sv
hdl/command_port.sv
hdl/phone_ui_top.sv
testbench/tb_phone_ui.sv

//--- Makefile
TOOL   = verilator
FLAGS  = --binary --timing --assert -j 0
TOP    = tb_phone_ui
FLIST  = list.f
OBJDIR = obj_dir
SIMBIN = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

run: compile
	@out="$$(./$(SIMBIN))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJDIR)
